// File: rtl/ip_mux_cfg.svh
`ifndef IP_MUX_CFG_SVH
`define IP_MUX_CFG_SVH

`default_nettype none

// number of source ports feeding the switch
`define IP_MUX_S_COUNT 4

// payload beat width in bits
`define IP_MUX_DATA_WIDTH 8

`default_nettype wire

`endif

// File: rtl/ip_mux_pkg.sv
`include "ip_mux_cfg.svh"
`default_nettype none

package ip_mux_pkg;

    // index of one source port
    typedef logic [$clog2(`IP_MUX_S_COUNT)-1:0] port_sel_t;

    // one payload beat
    typedef logic [`IP_MUX_DATA_WIDTH-1:0] payload_t;

    // reduced header fields
    typedef logic [15:0] eth_type_t;
    typedef logic [15:0] ip_len_t;
    typedef logic [7:0]  ip_ttl_t;
    typedef logic [7:0]  ip_proto_t;
    typedef logic [31:0] ip_addr_t;

    // frame lock state of the switch
    typedef enum logic {
        FRAME_IDLE,
        FRAME_ACTIVE
    } frame_state_t;

endpackage

`default_nettype wire

// File: rtl/ip_frame_switch.sv
`include "ip_mux_cfg.svh"
`default_nettype none

module ip_frame_switch (
    input  wire                                              clk,
    input  wire                                              rst,

    input  wire                                              enable,
    input  wire  ip_mux_pkg::port_sel_t                      select,

    // source header ports
    input  wire  [`IP_MUX_S_COUNT-1:0]                       s_hdr_valid,
    output logic [`IP_MUX_S_COUNT-1:0]                       s_hdr_ready,
    input  wire  ip_mux_pkg::eth_type_t [`IP_MUX_S_COUNT-1:0] s_eth_type,
    input  wire  ip_mux_pkg::ip_len_t   [`IP_MUX_S_COUNT-1:0] s_ip_length,
    input  wire  ip_mux_pkg::ip_ttl_t   [`IP_MUX_S_COUNT-1:0] s_ip_ttl,
    input  wire  ip_mux_pkg::ip_proto_t [`IP_MUX_S_COUNT-1:0] s_ip_protocol,
    input  wire  ip_mux_pkg::ip_addr_t  [`IP_MUX_S_COUNT-1:0] s_ip_source_ip,
    input  wire  ip_mux_pkg::ip_addr_t  [`IP_MUX_S_COUNT-1:0] s_ip_dest_ip,

    // source payload ports
    input  wire  ip_mux_pkg::payload_t  [`IP_MUX_S_COUNT-1:0] s_payload_data,
    input  wire  [`IP_MUX_S_COUNT-1:0]                       s_payload_valid,
    input  wire  [`IP_MUX_S_COUNT-1:0]                       s_payload_last,
    output logic [`IP_MUX_S_COUNT-1:0]                       s_payload_ready,

    // output header
    output logic                                             m_hdr_valid,
    input  wire                                              m_hdr_ready,
    output ip_mux_pkg::eth_type_t                            m_eth_type,
    output ip_mux_pkg::ip_len_t                              m_ip_length,
    output ip_mux_pkg::ip_ttl_t                              m_ip_ttl,
    output ip_mux_pkg::ip_proto_t                            m_ip_protocol,
    output ip_mux_pkg::ip_addr_t                             m_ip_source_ip,
    output ip_mux_pkg::ip_addr_t                             m_ip_dest_ip,

    // beat towards the skid buffer
    output ip_mux_pkg::payload_t                             int_data,
    output logic                                             int_valid,
    output logic                                             int_last,
    input  wire                                              ready_early
);

    ip_mux_pkg::frame_state_t   state_reg;
    ip_mux_pkg::frame_state_t   state_next;
    ip_mux_pkg::port_sel_t      select_reg;
    ip_mux_pkg::port_sel_t      select_next;
    logic [`IP_MUX_S_COUNT-1:0] payload_ready_next;
    logic                       frame_start;

    // start needs an idle switch, a free output header and a waiting source
    assign frame_start = (state_reg == ip_mux_pkg::FRAME_IDLE) && enable &&
                         !m_hdr_valid && s_hdr_valid[select];

    // locked port steers the payload
    assign int_data  = s_payload_data[select_reg];
    assign int_last  = s_payload_last[select_reg];
    assign int_valid = s_payload_valid[select_reg] && s_payload_ready[select_reg] &&
                       (state_reg == ip_mux_pkg::FRAME_ACTIVE);

    always_comb begin
        state_next  = state_reg;
        select_next = select_reg;

        // last beat accepted ends the frame
        if (int_valid && int_last) begin
            state_next = ip_mux_pkg::FRAME_IDLE;
        end

        if (frame_start) begin
            state_next  = ip_mux_pkg::FRAME_ACTIVE;
            select_next = select;
        end

        // only the locked port ever sees payload ready
        payload_ready_next = '0;
        if (ready_early && (state_next == ip_mux_pkg::FRAME_ACTIVE)) begin
            payload_ready_next[select_next] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg       <= ip_mux_pkg::FRAME_IDLE;
            select_reg      <= '0;
            s_hdr_ready     <= '0;
            s_payload_ready <= '0;
            m_hdr_valid     <= 1'b0;
        end else begin
            state_reg       <= state_next;
            select_reg      <= select_next;
            s_payload_ready <= payload_ready_next;

            // one cycle pulse to the chosen source
            s_hdr_ready <= '0;
            if (frame_start) begin
                s_hdr_ready[select] <= 1'b1;
            end

            if (frame_start) begin
                m_hdr_valid <= 1'b1;
            end else if (m_hdr_ready) begin
                m_hdr_valid <= 1'b0;
            end
        end

        // capture the selected header
        if (frame_start) begin
            m_eth_type     <= s_eth_type[select];
            m_ip_length    <= s_ip_length[select];
            m_ip_ttl       <= s_ip_ttl[select];
            m_ip_protocol  <= s_ip_protocol[select];
            m_ip_source_ip <= s_ip_source_ip[select];
            m_ip_dest_ip   <= s_ip_dest_ip[select];
        end
    end

endmodule

`default_nettype wire

// File: rtl/ip_payload_skid.sv
`default_nettype none

module ip_payload_skid (
    input  wire                        clk,
    input  wire                        rst,

    input  wire  ip_mux_pkg::payload_t int_data,
    input  wire                        int_valid,
    input  wire                        int_last,
    output logic                       ready_early,

    output ip_mux_pkg::payload_t       m_data,
    output logic                       m_valid,
    output logic                       m_last,
    input  wire                        m_ready
);

    logic                 ready_reg;
    logic                 m_valid_next;

    ip_mux_pkg::payload_t temp_data;
    logic                 temp_last;
    logic                 temp_valid;
    logic                 temp_valid_next;

    logic                 store_int_to_out;
    logic                 store_int_to_temp;
    logic                 store_temp_to_out;

    // can take a beat next cycle unless the temp register would have to fill
    assign ready_early = m_ready || (!temp_valid && (!m_valid || !int_valid));

    always_comb begin
        m_valid_next      = m_valid;
        temp_valid_next   = temp_valid;
        store_int_to_out  = 1'b0;
        store_int_to_temp = 1'b0;
        store_temp_to_out = 1'b0;

        if (ready_reg) begin
            if (m_ready || !m_valid) begin
                // output free or draining
                m_valid_next     = int_valid;
                store_int_to_out = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next   = int_valid;
                store_int_to_temp = 1'b1;
            end
        end else if (m_ready) begin
            // refill output from the parked beat
            m_valid_next      = temp_valid;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid    <= 1'b0;
            temp_valid <= 1'b0;
            ready_reg  <= 1'b0;
        end else begin
            m_valid    <= m_valid_next;
            temp_valid <= temp_valid_next;
            ready_reg  <= ready_early;
        end

        if (store_int_to_out) begin
            m_data <= int_data;
            m_last <= int_last;
        end else if (store_temp_to_out) begin
            m_data <= temp_data;
            m_last <= temp_last;
        end

        if (store_int_to_temp) begin
            temp_data <= int_data;
            temp_last <= int_last;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ip_mux.sv
`include "ip_mux_cfg.svh"
`default_nettype none

module ip_mux (
    input  wire                                              clk,
    input  wire                                              rst,

    input  wire                                              enable,
    input  wire  ip_mux_pkg::port_sel_t                      select,

    input  wire  [`IP_MUX_S_COUNT-1:0]                       s_hdr_valid,
    output logic [`IP_MUX_S_COUNT-1:0]                       s_hdr_ready,
    input  wire  ip_mux_pkg::eth_type_t [`IP_MUX_S_COUNT-1:0] s_eth_type,
    input  wire  ip_mux_pkg::ip_len_t   [`IP_MUX_S_COUNT-1:0] s_ip_length,
    input  wire  ip_mux_pkg::ip_ttl_t   [`IP_MUX_S_COUNT-1:0] s_ip_ttl,
    input  wire  ip_mux_pkg::ip_proto_t [`IP_MUX_S_COUNT-1:0] s_ip_protocol,
    input  wire  ip_mux_pkg::ip_addr_t  [`IP_MUX_S_COUNT-1:0] s_ip_source_ip,
    input  wire  ip_mux_pkg::ip_addr_t  [`IP_MUX_S_COUNT-1:0] s_ip_dest_ip,

    input  wire  ip_mux_pkg::payload_t  [`IP_MUX_S_COUNT-1:0] s_payload_data,
    input  wire  [`IP_MUX_S_COUNT-1:0]                       s_payload_valid,
    input  wire  [`IP_MUX_S_COUNT-1:0]                       s_payload_last,
    output logic [`IP_MUX_S_COUNT-1:0]                       s_payload_ready,

    output logic                                             m_hdr_valid,
    input  wire                                              m_hdr_ready,
    output ip_mux_pkg::eth_type_t                            m_eth_type,
    output ip_mux_pkg::ip_len_t                              m_ip_length,
    output ip_mux_pkg::ip_ttl_t                              m_ip_ttl,
    output ip_mux_pkg::ip_proto_t                            m_ip_protocol,
    output ip_mux_pkg::ip_addr_t                             m_ip_source_ip,
    output ip_mux_pkg::ip_addr_t                             m_ip_dest_ip,

    output ip_mux_pkg::payload_t                             m_data,
    output logic                                             m_valid,
    output logic                                             m_last,
    input  wire                                              m_ready
);

    // selected beat and buffer space between the two stages
    ip_mux_pkg::payload_t int_data;
    logic                 int_valid;
    logic                 int_last;
    logic                 ready_early;

    ip_frame_switch ip_frame_switch_inst (
        .clk             (clk),
        .rst             (rst),
        .enable          (enable),
        .select          (select),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_eth_type      (s_eth_type),
        .s_ip_length     (s_ip_length),
        .s_ip_ttl        (s_ip_ttl),
        .s_ip_protocol   (s_ip_protocol),
        .s_ip_source_ip  (s_ip_source_ip),
        .s_ip_dest_ip    (s_ip_dest_ip),
        .s_payload_data  (s_payload_data),
        .s_payload_valid (s_payload_valid),
        .s_payload_last  (s_payload_last),
        .s_payload_ready (s_payload_ready),
        .m_hdr_valid     (m_hdr_valid),
        .m_hdr_ready     (m_hdr_ready),
        .m_eth_type      (m_eth_type),
        .m_ip_length     (m_ip_length),
        .m_ip_ttl        (m_ip_ttl),
        .m_ip_protocol   (m_ip_protocol),
        .m_ip_source_ip  (m_ip_source_ip),
        .m_ip_dest_ip    (m_ip_dest_ip),
        .int_data        (int_data),
        .int_valid       (int_valid),
        .int_last        (int_last),
        .ready_early     (ready_early)
    );

    ip_payload_skid ip_payload_skid_inst (
        .clk         (clk),
        .rst         (rst),
        .int_data    (int_data),
        .int_valid   (int_valid),
        .int_last    (int_last),
        .ready_early (ready_early),
        .m_data      (m_data),
        .m_valid     (m_valid),
        .m_last      (m_last),
        .m_ready     (m_ready)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // reset held over the first 16 rising edges
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: testbench/tb_ip_mux.sv
`include "ip_mux_cfg.svh"
`default_nettype none

module tb_ip_mux;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PORTS      = `IP_MUX_S_COUNT;
    localparam int WAIT_LIMIT = 4000;

    typedef logic [PORTS-1:0] mask_t;

    typedef struct packed {
        ip_mux_pkg::eth_type_t eth_type;
        ip_mux_pkg::ip_len_t   length;
        ip_mux_pkg::ip_ttl_t   ttl;
        ip_mux_pkg::ip_proto_t protocol;
        ip_mux_pkg::ip_addr_t  source_ip;
        ip_mux_pkg::ip_addr_t  dest_ip;
    } hdr_t;

    typedef struct packed {
        logic                 last;
        ip_mux_pkg::payload_t data;
    } beat_t;

    logic                              clk;
    logic                              rst;
    logic                              enable;
    ip_mux_pkg::port_sel_t             select;
    mask_t                             s_hdr_valid;
    mask_t                             s_hdr_ready;
    ip_mux_pkg::eth_type_t [PORTS-1:0] s_eth_type;
    ip_mux_pkg::ip_len_t   [PORTS-1:0] s_ip_length;
    ip_mux_pkg::ip_ttl_t   [PORTS-1:0] s_ip_ttl;
    ip_mux_pkg::ip_proto_t [PORTS-1:0] s_ip_protocol;
    ip_mux_pkg::ip_addr_t  [PORTS-1:0] s_ip_source_ip;
    ip_mux_pkg::ip_addr_t  [PORTS-1:0] s_ip_dest_ip;
    ip_mux_pkg::payload_t  [PORTS-1:0] s_payload_data;
    mask_t                             s_payload_valid;
    mask_t                             s_payload_last;
    mask_t                             s_payload_ready;
    logic                              m_hdr_valid;
    logic                              m_hdr_ready;
    ip_mux_pkg::eth_type_t             m_eth_type;
    ip_mux_pkg::ip_len_t               m_ip_length;
    ip_mux_pkg::ip_ttl_t               m_ip_ttl;
    ip_mux_pkg::ip_proto_t             m_ip_protocol;
    ip_mux_pkg::ip_addr_t              m_ip_source_ip;
    ip_mux_pkg::ip_addr_t              m_ip_dest_ip;
    ip_mux_pkg::payload_t              m_data;
    logic                              m_valid;
    logic                              m_last;
    logic                              m_ready;

    // per-port source queues and the order the output must follow
    hdr_t        hdr_q[PORTS][$];
    beat_t       beat_q[PORTS][$];
    hdr_t        exp_hdr_q[$];
    beat_t       exp_beat_q[$];
    mask_t       beat_shown;
    mask_t       allowed_mask;
    logic        hdr_ready_level;
    logic        random_mode;
    logic [15:0] lfsr_state;
    int          frame_count;

    tb_clock tb_clock_inst (.clk(clk), .rst(rst));

    ip_mux ip_mux_inst (.*);

    // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], next_bit()};
        end
        return value;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected) else begin
            report_error($sformatf("Fail at %0d ns: %s expected %0h, got %0h",
                                   $time, name, expected, actual));
        end
    endtask

    task automatic queue_frame(input int port, input int len);
        hdr_t  h;
        beat_t b;
        h.eth_type  = ip_mux_pkg::eth_type_t'(rand_bits(16));
        h.length    = ip_mux_pkg::ip_len_t'(20 + len);
        h.ttl       = ip_mux_pkg::ip_ttl_t'(rand_bits(8));
        h.protocol  = ip_mux_pkg::ip_proto_t'(rand_bits(8));
        // frame number in the top byte keeps every header distinct
        h.source_ip = {8'(frame_count), 24'(rand_bits(24))};
        h.dest_ip   = rand_bits(32);
        hdr_q[port].push_back(h);
        exp_hdr_q.push_back(h);
        for (int i = 0; i < len; i++) begin
            b.data = ip_mux_pkg::payload_t'(rand_bits(`IP_MUX_DATA_WIDTH));
            b.last = (i == len - 1);
            beat_q[port].push_back(b);
            exp_beat_q.push_back(b);
        end
        frame_count++;
    endtask

    // advance one clock cycle
    // outputs are registered so this cycle's handshakes are already known here
    task automatic step();
        hdr_t  h;
        beat_t b;
        @(posedge clk);
        #1;
        check_value("s_hdr_ready off the locked port", '0,
                    128'(s_hdr_ready & ~allowed_mask));
        check_value("s_payload_ready off the locked port", '0,
                    128'(s_payload_ready & ~allowed_mask));
        for (int p = 0; p < PORTS; p++) begin
            s_hdr_valid[p] = (hdr_q[p].size() > 0);
            if (s_hdr_valid[p]) begin
                h                 = hdr_q[p][0];
                s_eth_type[p]     = h.eth_type;
                s_ip_length[p]    = h.length;
                s_ip_ttl[p]       = h.ttl;
                s_ip_protocol[p]  = h.protocol;
                s_ip_source_ip[p] = h.source_ip;
                s_ip_dest_ip[p]   = h.dest_ip;
            end
            // a shown beat stays valid until it is taken
            if (!beat_shown[p] && beat_q[p].size() > 0) begin
                beat_shown[p] = random_mode ? next_bit() : 1'b1;
            end
            s_payload_valid[p] = beat_shown[p];
            if (beat_shown[p]) begin
                s_payload_data[p] = beat_q[p][0].data;
                s_payload_last[p] = beat_q[p][0].last;
            end
            if (s_hdr_valid[p] && s_hdr_ready[p]) begin
                void'(hdr_q[p].pop_front());
            end
            if (s_payload_valid[p] && s_payload_ready[p]) begin
                void'(beat_q[p].pop_front());
                beat_shown[p] = 1'b0;
            end
        end
        m_ready     = random_mode ? next_bit() : 1'b1;
        m_hdr_ready = random_mode ? next_bit() : hdr_ready_level;
        if (m_hdr_valid && m_hdr_ready) begin
            assert (exp_hdr_q.size() > 0) else begin
                report_error("an output header arrived that no source sent");
            end
            h = exp_hdr_q.pop_front();
            check_value("m_eth_type", 128'(h.eth_type), 128'(m_eth_type));
            check_value("m_ip_length", 128'(h.length), 128'(m_ip_length));
            check_value("m_ip_ttl", 128'(h.ttl), 128'(m_ip_ttl));
            check_value("m_ip_protocol", 128'(h.protocol), 128'(m_ip_protocol));
            check_value("m_ip_source_ip", 128'(h.source_ip), 128'(m_ip_source_ip));
            check_value("m_ip_dest_ip", 128'(h.dest_ip), 128'(m_ip_dest_ip));
        end
        if (m_valid && m_ready) begin
            assert (exp_beat_q.size() > 0) else begin
                report_error("an output payload byte arrived that no source sent");
            end
            b = exp_beat_q.pop_front();
            check_value("m_data", 128'(b.data), 128'(m_data));
            check_value("m_last", 128'(b.last), 128'(m_last));
        end
    endtask

    task automatic wait_for_output(input int hdrs_left, input int beats_left,
                                   input string what);
        int count;
        count = 0;
        while ((exp_hdr_q.size() > hdrs_left || exp_beat_q.size() > beats_left) &&
               count < WAIT_LIMIT) begin
            step();
            count++;
        end
        if (exp_hdr_q.size() > hdrs_left || exp_beat_q.size() > beats_left) begin
            report_error({"timeout: the output never delivered ", what});
        end
    endtask

    // lock one port and send frames from it until all have left the output
    task automatic run_port(input int port, input int frames, input string what);
        select       = ip_mux_pkg::port_sel_t'(port);
        allowed_mask = mask_t'(1 << port);
        for (int f = 0; f < frames; f++) begin
            queue_frame(port, 1 + int'(rand_bits(5)));
        end
        wait_for_output(0, 0, what);
    endtask

    task automatic test_reset_state();
        for (int i = 0; i < 4; i++) begin
            step();
            check_value("s_hdr_ready", '0, 128'(s_hdr_ready));
            check_value("s_payload_ready", '0, 128'(s_payload_ready));
            check_value("m_hdr_valid", '0, 128'(m_hdr_valid));
            check_value("m_valid", '0, 128'(m_valid));
        end
    endtask

    task automatic test_single_frame();
        enable = 1'b1;
        run_port(0, 1, "a single frame from port 0");
    endtask

    task automatic test_every_port();
        int left;
        left = 0;
        for (int p = 0; p < PORTS; p++) begin
            queue_frame(p, 4 + p);
            left += 4 + p;
        end
        for (int p = 0; p < PORTS; p++) begin
            select       = ip_mux_pkg::port_sel_t'(p);
            allowed_mask = mask_t'(1 << p);
            left -= 4 + p;
            wait_for_output(PORTS - 1 - p, left, "a frame from each port in turn");
        end
    endtask

    task automatic test_enable_gating();
        enable       = 1'b0;
        select       = ip_mux_pkg::port_sel_t'(1);
        allowed_mask = '0;
        queue_frame(1, 6);
        for (int i = 0; i < 30; i++) begin
            step();
            check_value("m_hdr_valid", '0, 128'(m_hdr_valid));
        end
        enable       = 1'b1;
        allowed_mask = mask_t'(2);
        wait_for_output(0, 0, "the frame held back by enable");
    endtask

    task automatic test_frame_lock();
        hdr_ready_level = 1'b0;
        select          = ip_mux_pkg::port_sel_t'(1);
        allowed_mask    = mask_t'(2);
        queue_frame(1, 12);
        queue_frame(2, 5);
        wait_for_output(2, 11, "the first bytes of the locked frame");
        // select moves mid-frame but port 1 stays locked
        select = ip_mux_pkg::port_sel_t'(2);
        wait_for_output(2, 5, "the rest of the locked frame");
        for (int i = 0; i < 20; i++) begin
            step();
            check_value("m_hdr_valid", 128'(1), 128'(m_hdr_valid));
        end
        hdr_ready_level = 1'b1;
        allowed_mask    = mask_t'(4);
        wait_for_output(0, 0, "the second frame after the header was taken");
    endtask

    task automatic test_back_pressure();
        random_mode = 1'b1;
        for (int v = 0; v < 4; v++) begin
            run_port(int'(rand_bits(2)) % PORTS, 2, "frames under random back-pressure");
        end
        random_mode = 1'b0;
    endtask

    initial begin
        int count;
        enable          = 1'b0;
        select          = '0;
        s_hdr_valid     = '0;
        s_eth_type      = '0;
        s_ip_length     = '0;
        s_ip_ttl        = '0;
        s_ip_protocol   = '0;
        s_ip_source_ip  = '0;
        s_ip_dest_ip    = '0;
        s_payload_data  = '0;
        s_payload_valid = '0;
        s_payload_last  = '0;
        m_hdr_ready     = 1'b1;
        m_ready         = 1'b1;
        beat_shown      = '0;
        allowed_mask    = '0;
        hdr_ready_level = 1'b1;
        random_mode     = 1'b0;
        lfsr_state      = 16'd57687;
        frame_count     = 0;

        count = 0;
        while (rst !== 1'b0 && count < 40) begin
            step();
            count++;
        end
        if (rst !== 1'b0) begin
            report_error("timeout: reset was never released");
        end

        test_reset_state();
        test_single_frame();
        test_every_port();
        test_enable_gating();
        test_frame_lock();
        test_back_pressure();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: ip_mux.f
+incdir+rtl
rtl/ip_mux_pkg.sv
rtl/ip_frame_switch.sv
rtl/ip_payload_skid.sv
rtl/ip_mux.sv
testbench/tb_clock.sv
testbench/tb_ip_mux.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ip_mux testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_ip_mux -f ip_mux.f --Mdir obj_dir -o sim_ip_mux
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_ip_mux
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0
